// File: include/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Data word width, fixed by RV32
`define EXEC_XLEN 32

// Shift amount comes from the low bits of rs2
`define EXEC_SHAMT_W 5

// mul only needs the low half of the product
`define EXEC_MUL_STEPS_LOW 32

// mulh, mulhsu and mulhu need the full 64-bit product
`define EXEC_MUL_STEPS_FULL 64

`define EXEC_DIV_STEPS 32 // One quotient bit per step

`endif

// File: design/exec_pkg.sv
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0]   xlen_t;
  typedef logic [2*`EXEC_XLEN-1:0] dword_t;  // Product or remainder:quotient pair
  typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;
  typedef logic [6:0]              step_t;   // Up to 64 multiply steps

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_mul,    // M extension from here on
    op_mulh,
    op_mulhsu,
    op_mulhu,
    op_div,
    op_divu,
    op_rem,
    op_remu
  } exec_op_t;

  // Operation as captured at the boundary
  typedef struct packed {
    exec_op_t op;
    xlen_t    rs1;
    xlen_t    rs2;
  } exec_req_t;

  typedef enum logic [2:0] {
    st_idle,
    st_alu,
    st_mul_wait,
    st_div_wait,
    st_hold      // ack high until req drops
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu
  import exec_pkg::*;
(
  input  exec_op_t op,
  input  xlen_t    rs1,
  input  xlen_t    rs2,
  output xlen_t    y
);

  shamt_t shamt;
  logic   lt_signed;
  logic   lt_unsigned;

  assign shamt = rs2[4:0]; // No separate shamt port

  assign lt_signed   = $signed(rs1) < $signed(rs2);
  assign lt_unsigned = rs1 < rs2;

  always_comb begin
    case (op)
      op_add: begin
        y = rs1 + rs2;
      end
      op_sub: begin
        y = rs1 - rs2;
      end
      op_sll: begin
        y = rs1 << shamt;
      end
      op_slt: begin
        y = xlen_t'(lt_signed);
      end
      op_sltu: begin
        y = xlen_t'(lt_unsigned);
      end
      op_xor: begin
        y = rs1 ^ rs2;
      end
      op_srl: begin
        y = rs1 >> shamt;
      end
      op_sra: begin
        y = xlen_t'($signed(rs1) >>> shamt); // Sign bit fills from the left
      end
      op_or: begin
        y = rs1 | rs2;
      end
      op_and: begin
        y = rs1 & rs2;
      end
      // Multiply and divide are handled by the iterative units
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module mul_unit
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  input  exec_req_t req,
  output logic      done,
  output xlen_t     result
);

  dword_t mcand;     // Shifts left each step
  dword_t mplier;    // Shifts right each step
  dword_t acc;
  step_t  count;
  logic   busy;
  logic   low_half;  // mul returns the low word
  dword_t ext_a;
  dword_t ext_b;

  // Sign extension per operation
  always_comb begin
    ext_a = {32'b0, req.rs1};
    ext_b = {32'b0, req.rs2};
    case (req.op)
      op_mulh: begin
        ext_a = {{32{req.rs1[31]}}, req.rs1};
        ext_b = {{32{req.rs2[31]}}, req.rs2};
      end
      op_mulhsu: begin
        ext_a = {{32{req.rs1[31]}}, req.rs1};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        if (req.op == op_mul) begin
          count <= step_t'(`EXEC_MUL_STEPS_LOW);
        end else begin
          count <= step_t'(`EXEC_MUL_STEPS_FULL);
        end
      end else if (busy) begin
        if (count != '0) begin
          count <= count - 1'b1;
        end else begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      mcand    <= ext_a;
      mplier   <= ext_b;
      acc      <= '0;
      low_half <= (req.op == op_mul);
    end else if (busy) begin
      if (count != '0) begin
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end else begin
        result <= low_half ? acc[31:0] : acc[63:32];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module div_unit
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      start,
  input  exec_req_t req,
  output logic      done,
  output xlen_t     result
);

  typedef enum logic [1:0] {
    div_idle,
    div_run,
    div_fixup,
    div_finish
  } div_state_t;

  div_state_t  state;
  xlen_t       divisor;
  dword_t      rq;        // Remainder high, quotient low
  step_t       count;
  logic        neg_q;
  logic        neg_r;
  logic        want_rem;
  xlen_t       res;
  logic        is_signed;
  logic        is_rem;
  logic        by_zero;
  logic        overflow;
  xlen_t       abs_a;
  xlen_t       abs_b;
  dword_t      shifted;
  logic [32:0] trial;

  always_comb begin
    is_signed = (req.op == op_div) || (req.op == op_rem);
    is_rem    = (req.op == op_rem) || (req.op == op_remu);
    by_zero   = (req.rs2 == '0);
    // Most negative value over minus one
    overflow  = is_signed && (req.rs1 == {1'b1, 31'b0}) && (req.rs2 == '1);
    abs_a     = (is_signed && req.rs1[31]) ? -req.rs1 : req.rs1;
    abs_b     = (is_signed && req.rs2[31]) ? -req.rs2 : req.rs2;
  end

  // Restoring step
  assign shifted = {rq[62:0], 1'b0};
  assign trial   = {1'b0, shifted[63:32]} - {1'b0, divisor};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        div_idle: begin
          if (start) begin
            count <= step_t'(`EXEC_DIV_STEPS);
            state <= (by_zero || overflow) ? div_finish : div_run; // Special cases skip the loop
          end
        end
        div_run: begin
          count <= count - 1'b1;
          if (count == step_t'(1)) begin
            state <= div_fixup;
          end
        end
        div_fixup: begin
          state <= div_finish;
        end
        default: begin
          done  <= 1'b1;
          state <= div_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      div_idle: begin
        if (start) begin
          divisor  <= abs_b;
          rq       <= {32'b0, abs_a};
          neg_q    <= is_signed && (req.rs1[31] ^ req.rs2[31]);
          neg_r    <= is_signed && req.rs1[31]; // Remainder follows the dividend
          want_rem <= is_rem;
          if (by_zero) begin
            res <= is_rem ? req.rs1 : '1;
          end else if (overflow) begin
            res <= is_rem ? '0 : req.rs1;
          end
        end
      end
      div_run: begin
        if (!trial[32]) begin
          rq <= {trial[31:0], shifted[31:1], 1'b1};
        end else begin
          rq <= shifted;
        end
      end
      div_fixup: begin
        if (want_rem) begin
          res <= neg_r ? -rq[63:32] : rq[63:32];
        end else begin
          res <= neg_q ? -rq[31:0] : rq[31:0];
        end
      end
      default: begin
        result <= res;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req,
  input  exec_req_t request,
  output logic      ack,
  output xlen_t     result
);

  ctrl_state_t state;
  exec_req_t   cap;         // Request held for the whole operation
  xlen_t       alu_y;
  xlen_t       mul_result;
  xlen_t       div_result;
  logic        mul_start;
  logic        mul_done;
  logic        div_start;
  logic        div_done;

  int_alu i_int_alu (
    .op  (cap.op),
    .rs1 (cap.rs1),
    .rs2 (cap.rs2),
    .y   (alu_y)
  );

  mul_unit i_mul_unit (
    .clk    (clk),
    .reset  (reset),
    .start  (mul_start),
    .req    (cap),
    .done   (mul_done),
    .result (mul_result)
  );

  div_unit i_div_unit (
    .clk    (clk),
    .reset  (reset),
    .start  (div_start),
    .req    (cap),
    .done   (div_done),
    .result (div_result)
  );

  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      cap <= request;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      ack       <= 1'b0;
      result    <= '0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      mul_start <= 1'b0; // Single-cycle pulses
      div_start <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            case (request.op)
              op_mul, op_mulh, op_mulhsu, op_mulhu: begin
                state     <= st_mul_wait;
                mul_start <= 1'b1;
              end
              op_div, op_divu, op_rem, op_remu: begin
                state     <= st_div_wait;
                div_start <= 1'b1;
              end
              default: begin
                state <= st_alu;
              end
            endcase
          end
        end
        st_alu: begin
          result <= alu_y;
          ack    <= 1'b1;
          state  <= st_hold;
        end
        st_mul_wait: begin
          if (mul_done) begin
            result <= mul_result;
            ack    <= 1'b1;
            state  <= st_hold;
          end
        end
        st_div_wait: begin
          if (div_done) begin
            result <= div_result;
            ack    <= 1'b1;
            state  <= st_hold;
          end
        end
        // Result stays put until the requester lets go
        st_hold: begin
          if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verification/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb
  import exec_pkg::*;
();

  logic      clk;
  logic      reset;
  logic      req;
  exec_req_t request;
  logic      ack;
  xlen_t     result;
  xlen_t     expected;
  xlen_t     corners [4];
  logic      reset_q = 1'b0;
  logic      ack_q = 1'b0;
  int        req_wait = 0;   // Cycles with req high and no ack yet
  int        drop_wait = 0;  // Cycles with ack still high after req fell
  int        cycle_count = 0;
  int        txn_count = 0;
  int        ack_count = 0;

  exec_unit i_exec_unit (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .request (request),
    .ack     (ack),
    .result  (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Expected value from the RV32IM rules, in 64-bit arithmetic
  function automatic xlen_t model(input exec_op_t kind, input xlen_t a, input xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        y;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (kind)
      op_add:    y = ua + ub;
      op_sub:    y = ua - ub;
      op_sll:    y = ua << b[4:0];
      op_slt:    y = {63'b0, $signed(a) < $signed(b)};
      op_sltu:   y = {63'b0, a < b};
      op_xor:    y = ua ^ ub;
      op_srl:    y = ua >> b[4:0];
      op_sra:    y = sa >>> b[4:0];
      op_or:     y = ua | ub;
      op_and:    y = ua & ub;
      op_mul:    y = ua * ub;
      op_mulh:   y = (sa * sb) >> 32;
      op_mulhsu: y = (sa * ub) >> 32;
      op_mulhu:  y = (ua * ub) >> 32;
      op_div:    y = sa / sb;  // Overflow case wraps to the dividend
      op_divu:   y = ua / ub;
      op_rem:    y = sa % sb;
      op_remu:   y = ua % ub;
      default:   y = '0;
    endcase
    if (b == '0 && kind inside {op_div, op_divu}) begin
      y = '1;
    end else if (b == '0 && kind inside {op_rem, op_remu}) begin
      y = ua;
    end
    return y[31:0];
  endfunction

  function automatic xlen_t pick_operand();
    case ($urandom_range(0, 7))
      0: return '0;
      1: return '1;
      2: return 32'h8000_0000;
      3: return xlen_t'($urandom_range(0, 40));  // Small values, shift amounts
      default: return $urandom;
    endcase
  endfunction

  // One full four-phase transaction
  task automatic run_op(input exec_op_t kind, input xlen_t a, input xlen_t b,
                        input int max_hold);
    int hold;
    hold = $urandom_range(0, max_hold);
    expected <= model(kind, a, b);
    request  <= {kind, a, b};
    req      <= 1'b1;
    txn_count++;
    @(posedge clk iff ack);
    repeat (hold) @(posedge clk);  // Requester lingers in hold
    req <= 1'b0;
    @(posedge clk iff !ack);
  endtask

  task automatic run_random(input int lo, input int hi, input int count, input int max_hold);
    repeat (count) begin
      run_op(exec_op_t'($urandom_range(lo, hi)), pick_operand(), pick_operand(), max_hold);
    end
  endtask

  always @(posedge clk) begin
    reset_q     <= reset;
    ack_q       <= ack;
    cycle_count <= cycle_count + 1;
    req_wait    <= (req && !ack) ? req_wait + 1 : 0;
    drop_wait   <= (ack && !req) ? drop_wait + 1 : 0;
    if (ack && !ack_q) begin
      ack_count <= ack_count + 1;
    end
    // Expected run is about 29000 cycles
    if (cycle_count >= 60000) begin
      stop_on_error("Timeout: the run did not finish within 60000 cycles");
    end
  end

  ack_low_after_reset: assert property (@(posedge clk) reset_q |-> !ack)
    else stop_on_error("ack was not low after reset");

  ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else stop_on_error("ack rose while req was low");

  result_held: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> $stable(result))
    else stop_on_error("result changed while ack was high");

  ack_drops: assert property (@(posedge clk) disable iff (reset) drop_wait <= 2)
    else stop_on_error("ack stayed high more than 2 cycles after req fell");

  ack_in_time: assert property (@(posedge clk) disable iff (reset) req_wait <= 70)
    else stop_on_error("ack did not rise within 70 cycles of req");

  result_correct: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> result == expected)
    else stop_on_error($sformatf("Error result: got 0x%08h expected 0x%08h",
                                 $sampled(result), $sampled(expected)));

  initial begin
    void'($urandom(44654));
    corners  = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_001f};
    reset    = 1'b1;
    req      = 1'b0;
    request  = '0;
    expected = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Every operation over all corner pairs, including divide by zero and overflow
    for (int k = 0; k < 18; k++) begin
      for (int i = 0; i < 16; i++) begin
        run_op(exec_op_t'(k), corners[i / 4], corners[i % 4], 3);
      end
    end

    run_random(0, 9, 300, 3);     // Base ALU
    run_random(10, 13, 150, 3);   // Multiply
    run_random(14, 17, 150, 3);   // Divide and remainder
    run_random(0, 17, 100, 8);    // Mixed traffic, longer holds

    @(posedge clk);
    if (ack_count == txn_count) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_error($sformatf("Error ack_count: got 0x%0h expected 0x%0h",
                              ack_count, txn_count));
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
design/exec_pkg.sv
design/int_alu.sv
design/mul_unit.sv
design/div_unit.sv
design/exec_unit.sv
verification/exec_unit_tb.sv
